/* tb.f */
common/sink_cfg_pkg.sv
common/stream_pkg.sv
design/sink_regs.sv
sink/sink_addrgen.sv
sink/sink_addr_fifo.sv
sink/sink_core.sv
design/sink_top.sv
sim/tb_sink_top.sv

/* Bender.yml */
package:
  name: sink

dependencies: {}

sources:
  - common/sink_cfg_pkg.sv
  - common/stream_pkg.sv
  - design/sink_regs.sv
  - sink/sink_addrgen.sv
  - sink/sink_addr_fifo.sv
  - sink/sink_core.sv
  - design/sink_top.sv
  - target: test
    files:
      - sim/tb_sink_top.sv

/* sim/tb_sink_top.sv */
`default_nettype none

module tb_sink_top;

  localparam int unsigned NJOBS = 8;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     cfg_req_i;
  logic                     cfg_we_i;
  logic [2:0]               cfg_addr_i;
  logic [31:0]              cfg_wdata_i;
  logic                     cfg_ack_o;
  logic [31:0]              cfg_rdata_o;
  stream_pkg::stream_beat_t stream_i;
  logic                     stream_ready_o;
  stream_pkg::mem_req_t     mem_o;
  logic                     mem_gnt_i;

  integer               seed = 77339;
  int unsigned          cycle_cnt, cycle_limit;
  int unsigned          wr_cnt, beats_left, stall_cnt;
  bit                   run_en, stall_mode, beat_taken, wait_q;
  stream_pkg::mem_req_t held_q; // request seen while grant was low
  logic [31:0]          job_base [NJOBS], job_d0s [NJOBS], job_d1s [NJOBS];
  logic [15:0]          job_d0l [NJOBS], job_tot [NJOBS];
  logic [31:0]          exp_addr_q [$], job_addr_q [$];
  logic [35:0]          sent_q [$]; // {data, strb} in send order
  logic [31:0]          model_mem [logic [31:0]];
  logic [31:0]          ref_mem [logic [31:0]];

  sink_top #(
    .FIFO_DEPTH ( 2 )
  ) UUT (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .cfg_req_i      ( cfg_req_i      ),
    .cfg_we_i       ( cfg_we_i       ),
    .cfg_addr_i     ( cfg_addr_i     ),
    .cfg_wdata_i    ( cfg_wdata_i    ),
    .cfg_ack_o      ( cfg_ack_o      ),
    .cfg_rdata_o    ( cfg_rdata_o    ),
    .stream_i       ( stream_i       ),
    .stream_ready_o ( stream_ready_o ),
    .mem_o          ( mem_o          ),
    .mem_gnt_i      ( mem_gnt_i      )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // one four-phase transfer, ack must follow req by exactly one cycle
  task automatic bus_access(input logic we, input logic [2:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk_i);
    check_value("cfg_ack_o", cfg_ack_o, 32'd0);
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    @(negedge clk_i);
    check_value("cfg_ack_o", cfg_ack_o, 32'd1);
    rdata     = cfg_rdata_o;
    cfg_req_i = 1'b0;
    @(negedge clk_i);
    check_value("cfg_ack_o", cfg_ack_o, 32'd0); // released after req dropped
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, rdata);
  endtask

  task automatic write_model(input logic [31:0] a, input logic [3:0] be, input logic [31:0] d);
    logic [31:0] word;
    word = model_mem.exists(a) ? model_mem[a] : 32'h0;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) word[8*b +: 8] = d[8*b +: 8];
    end
    model_mem[a] = word;
  endtask

  // memory side monitor, values seen here are the ones the DUT samples
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      stop_run("timeout: the jobs did not complete within the cycle limit");
    end else begin
      if (wait_q) begin
        check_value("mem_o.req", mem_o.req, 32'd1);
        check_value("mem_o.addr", mem_o.addr, held_q.addr);
        check_value("mem_o.be", mem_o.be, held_q.be);
        check_value("mem_o.data", mem_o.data, held_q.data);
      end
      wait_q = mem_o.req & ~mem_gnt_i;
      held_q = mem_o;
      if (rst_ni) begin
        // a beat is only taken together with a granted write
        check_value("stream_ready_o", stream_ready_o,
                    !stream_i.valid || (mem_o.req && mem_gnt_i));
      end
      if (stream_i.valid && stream_ready_o) beat_taken = 1'b1;
      if (mem_o.req && mem_gnt_i) begin
        if (exp_addr_q.size() == 0) begin
          stop_run("a write was granted beyond the programmed length");
        end else begin
          check_value("mem_o.addr", mem_o.addr, exp_addr_q.pop_front());
          write_model(mem_o.addr, mem_o.be, mem_o.data);
          wr_cnt++;
        end
      end
    end
  end

  // stream and grant driver
  always @(negedge clk_i) begin
    if (run_en) begin
      if (beat_taken) begin
        stream_i.valid = 1'b0;
        beat_taken     = 1'b0;
      end
      if (!stream_i.valid && beats_left > 0 && ($random(seed) & 3) != 0) begin
        stream_i.data  = $random(seed);
        stream_i.strb  = $random(seed);
        stream_i.valid = 1'b1;
        sent_q.push_back({stream_i.data, stream_i.strb});
        beats_left--;
      end
      if (stall_cnt > 0) begin
        mem_gnt_i = 1'b0;
        stall_cnt--;
      end else if (stall_mode && ($random(seed) & 7) == 0) begin
        mem_gnt_i = 1'b0;
        stall_cnt = 2 + ($random(seed) & 7); // grant held low for a while
      end else begin
        mem_gnt_i = ($unsigned($random(seed)) % 10) < 6;
      end
    end
  end

  initial begin
    logic [31:0] rd, a, mask, old;
    logic [31:0] vals [5];
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = 3'd0;
    cfg_wdata_i = 32'h0;
    stream_i    = '0;
    mem_gnt_i   = 1'b0;
    rst_ni      = 1'b0;
    cycle_limit = 200;
    for (int j = 0; j < NJOBS; j++) begin
      job_base[j] = $random(seed) & 32'h0000_0ffc;
      job_d0s[j]  = $unsigned($random(seed)) % 5;
      job_d1s[j]  = $unsigned($random(seed)) % 64;
      job_d0l[j]  = 1 + $unsigned($random(seed)) % 6;
      job_tot[j]  = 1 + $unsigned($random(seed)) % 24;
      cycle_limit += 20 * job_tot[j];
    end
    cycle_limit += 50 * (NJOBS * 13 + 1); // 13 bus accesses per job, one after reset
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_value("cfg_ack_o", cfg_ack_o, 32'd0);
    check_value("mem_o.req", mem_o.req, 32'd0);
    rst_ni = 1'b1;
    bus_read(sink_cfg_pkg::REG_TOT_LEN, rd);
    check_value("cfg_rdata_o", rd, 32'h0);
    @(posedge clk_i);
    run_en = 1'b1;
    for (int j = 0; j < NJOBS; j++) begin
      vals = '{job_base[j], job_d0s[j], {16'h0, job_d0l[j]}, job_d1s[j], {16'h0, job_tot[j]}};
      for (int r = 0; r < 5; r++) bus_write(sink_cfg_pkg::reg_idx_e'(r), vals[r]);
      for (int r = 0; r < 5; r++) begin
        bus_read(sink_cfg_pkg::reg_idx_e'(r), rd);
        check_value("cfg_rdata_o", rd, vals[r]);
      end
      job_addr_q.delete();
      sent_q.delete();
      for (int k = 0; k < job_tot[j]; k++) begin
        job_addr_q.push_back(job_base[j] + (k % job_d0l[j]) * job_d0s[j] +
                             (k / job_d0l[j]) * job_d1s[j]);
      end
      exp_addr_q = job_addr_q;
      wr_cnt     = 0;
      @(posedge clk_i);
      beats_left = job_tot[j];
      stall_mode = (j >= NJOBS / 2);
      bus_write(sink_cfg_pkg::REG_CTRL, 32'd1);
      bus_write(sink_cfg_pkg::REG_CTRL, 32'd1); // arrives while the job is busy
      while (wr_cnt < job_tot[j]) @(negedge clk_i);
      repeat (4) @(negedge clk_i);
      check_value("wr_cnt", wr_cnt, job_tot[j]);
      check_value("sent_q.size", sent_q.size(), job_tot[j]);
      bus_read(sink_cfg_pkg::REG_STATUS, rd);
      check_value("REG_STATUS", rd, 32'h2); // done set, busy clear
      for (int k = 0; k < job_tot[j]; k++) begin
        a    = job_addr_q[k];
        mask = {{8{sent_q[k][3]}}, {8{sent_q[k][2]}}, {8{sent_q[k][1]}}, {8{sent_q[k][0]}}};
        old  = ref_mem.exists(a) ? ref_mem[a] : 32'h0;
        ref_mem[a] = (old & ~mask) | (sent_q[k][35:4] & mask);
      end
      foreach (ref_mem[addr]) check_value("model_mem", model_mem[addr], ref_mem[addr]);
      check_value("model_mem.num", model_mem.num(), ref_mem.num());
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* design/sink_top.sv */
`default_nettype none

module sink_top #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     cfg_req_i,
  input  wire logic                     cfg_we_i,
  input  wire logic [2:0]               cfg_addr_i,
  input  wire logic [31:0]              cfg_wdata_i,
  output logic                          cfg_ack_o,
  output logic [31:0]                   cfg_rdata_o,
  input  wire stream_pkg::stream_beat_t stream_i,
  output logic                          stream_ready_o,
  output stream_pkg::mem_req_t          mem_o,
  input  wire logic                     mem_gnt_i
);

  sink_cfg_pkg::job_cfg_t    cfg;
  sink_cfg_pkg::sink_state_e core_state;
  logic        start, core_done;
  logic [31:0] gen_addr, fifo_addr;
  logic        gen_valid, gen_ready;
  logic        fifo_valid, fifo_ready;

  sink_regs u_regs (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .cfg_req_i    ( cfg_req_i   ),
    .cfg_we_i     ( cfg_we_i    ),
    .cfg_addr_i   ( cfg_addr_i  ),
    .cfg_wdata_i  ( cfg_wdata_i ),
    .cfg_ack_o    ( cfg_ack_o   ),
    .cfg_rdata_o  ( cfg_rdata_o ),
    .core_state_i ( core_state  ),
    .done_i       ( core_done   ),
    .cfg_o        ( cfg         ),
    .start_o      ( start       )
  );

  sink_addrgen u_addrgen (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .start_i      ( start     ),
    .cfg_i        ( cfg       ),
    .addr_o       ( gen_addr  ),
    .addr_valid_o ( gen_valid ),
    .addr_ready_i ( gen_ready )
  );

  sink_addr_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .push_data_i  ( gen_addr   ),
    .push_valid_i ( gen_valid  ),
    .push_ready_o ( gen_ready  ),
    .pop_data_o   ( fifo_addr  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_ready_i  ( fifo_ready )
  );

  sink_core u_core (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .start_i        ( start          ),
    .tot_len_i      ( cfg.tot_len    ),
    .stream_i       ( stream_i       ),
    .stream_ready_o ( stream_ready_o ),
    .addr_i         ( fifo_addr      ),
    .addr_valid_i   ( fifo_valid     ),
    .addr_ready_o   ( fifo_ready     ),
    .mem_o          ( mem_o          ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .state_o        ( core_state     ),
    .done_o         ( core_done      )
  );

endmodule

`default_nettype wire

/* sink/sink_core.sv */
`default_nettype none

module sink_core (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      start_i,
  input  wire logic [15:0]               tot_len_i,
  input  wire stream_pkg::stream_beat_t  stream_i,
  output logic                           stream_ready_o,
  input  wire logic [31:0]               addr_i,
  input  wire logic                      addr_valid_i,
  output logic                           addr_ready_o,
  output stream_pkg::mem_req_t           mem_o,
  input  wire logic                      mem_gnt_i,
  output sink_cfg_pkg::sink_state_e      state_o,
  output logic                           done_o
);

  sink_cfg_pkg::sink_state_e state_d, state_q;
  logic [15:0] cnt_q;   // granted writes of the current job
  logic        active;
  logic        fire;    // write completes this cycle
  logic        last;
  logic        done_d, done_q;

  assign active = (state_q != sink_cfg_pkg::ST_IDLE);
  assign fire   = mem_o.req & mem_gnt_i;
  assign last   = (cnt_q == tot_len_i - 16'd1);

  // memory port binding, beat and address go out together
  assign mem_o.req  = active & stream_i.valid & addr_valid_i;
  assign mem_o.addr = addr_i;
  assign mem_o.be   = stream_i.strb;
  assign mem_o.data = stream_i.data;

  assign stream_ready_o = ~stream_i.valid | fire;
  assign addr_ready_o   = fire; // pop the address with its beat

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      sink_cfg_pkg::ST_IDLE: begin
        if (start_i) begin
          if (tot_len_i == 16'd0) begin
            state_d = sink_cfg_pkg::ST_DRAIN; // empty job finishes at once
            done_d  = 1'b1;
          end else begin
            state_d = sink_cfg_pkg::ST_WORKING;
          end
        end
      end
      sink_cfg_pkg::ST_WORKING: begin
        if (fire && last) begin
          state_d = sink_cfg_pkg::ST_DRAIN;
          done_d  = 1'b1;
        end
      end
      sink_cfg_pkg::ST_DRAIN: state_d = sink_cfg_pkg::ST_IDLE;
      default: state_d = sink_cfg_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= sink_cfg_pkg::ST_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d; // high during ST_DRAIN
      if (!active && start_i) cnt_q <= '0;
      else if (fire) cnt_q <= cnt_q + 16'd1;
    end
  end

  assign state_o = state_q;
  assign done_o  = done_q;

  // FIFO is empty whenever the core is idle, so no write can leak out
  a_no_req_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == sink_cfg_pkg::ST_IDLE) |-> !addr_valid_i && !mem_o.req);

endmodule

`default_nettype wire

/* sink/sink_addr_fifo.sv */
`default_nettype none

module sink_addr_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic [31:0] push_data_i,
  input  wire logic        push_valid_i,
  output logic             push_ready_o,
  output logic [31:0]      pop_data_o,
  output logic             pop_valid_o,
  input  wire logic        pop_ready_i
);

  localparam int unsigned PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  logic [31:0]   mem_q [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push, pop;

  assign push_ready_o = (count_q != CW'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign pop_data_o = mem_q[rd_ptr_q];

  // generator keeps offering while full, nothing gets lost
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_i && !push_ready_o |=> push_valid_i);

  // core only takes an address when a write with it is granted
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ready_i |-> pop_valid_o);

endmodule

`default_nettype wire

/* sink/sink_addrgen.sv */
`default_nettype none

module sink_addrgen (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  input  wire sink_cfg_pkg::job_cfg_t cfg_i,
  output logic [31:0]                 addr_o,
  output logic                        addr_valid_o,
  input  wire logic                   addr_ready_i
);

  logic        valid_q;
  logic [15:0] inner_cnt_q; // position inside the current run
  logic [15:0] tot_cnt_q;   // addresses handed out so far
  logic [31:0] outer_q;     // start address of the current run
  logic [31:0] addr_q;
  logic        step;
  logic        last_inner;
  logic        last_total;

  assign step       = valid_q & addr_ready_i;
  assign last_inner = (inner_cnt_q == cfg_i.d0_len - 16'd1);
  assign last_total = (tot_cnt_q == cfg_i.tot_len - 16'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      inner_cnt_q <= '0;
      tot_cnt_q   <= '0;
      outer_q     <= '0;
      addr_q      <= '0;
    end else if (start_i) begin
      valid_q     <= (cfg_i.tot_len != 16'd0);
      inner_cnt_q <= '0;
      tot_cnt_q   <= '0;
      outer_q     <= cfg_i.base;
      addr_q      <= cfg_i.base;
    end else if (step) begin
      tot_cnt_q <= tot_cnt_q + 16'd1;
      if (last_total) begin
        valid_q <= 1'b0; // job fully generated
      end else if (last_inner) begin
        inner_cnt_q <= '0;
        outer_q     <= outer_q + cfg_i.d1_stride;
        addr_q      <= outer_q + cfg_i.d1_stride;
      end else begin
        inner_cnt_q <= inner_cnt_q + 16'd1;
        addr_q      <= addr_q + cfg_i.d0_stride;
      end
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;

  // an offered address is held until the FIFO takes it
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_valid_o && !addr_ready_i |=> addr_valid_o && $stable(addr_o));

endmodule

`default_nettype wire

/* design/sink_regs.sv */
`default_nettype none

module sink_regs (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      cfg_req_i,
  input  wire logic                      cfg_we_i,
  input  wire logic [2:0]                cfg_addr_i,
  input  wire logic [31:0]               cfg_wdata_i,
  output logic                           cfg_ack_o,
  output logic [31:0]                    cfg_rdata_o,
  input  wire sink_cfg_pkg::sink_state_e core_state_i,
  input  wire logic                      done_i,
  output sink_cfg_pkg::job_cfg_t         cfg_o,
  output logic                           start_o
);

  sink_cfg_pkg::job_cfg_t   cfg_q;
  sink_cfg_pkg::reg_idx_e   reg_idx;
  logic                     ack_q;
  logic                     access;
  logic                     busy;
  logic                     start_d, start_q;
  logic                     done_q;
  logic [31:0]              rdata_d, rdata_q;

  assign reg_idx = sink_cfg_pkg::reg_idx_e'(cfg_addr_i);
  assign access  = cfg_req_i & ~ack_q; // first cycle of a new request
  assign busy    = (core_state_i != sink_cfg_pkg::ST_IDLE);

  // a start while a job runs is dropped here already
  assign start_d = access & cfg_we_i & (reg_idx == sink_cfg_pkg::REG_CTRL) &
                   cfg_wdata_i[0] & ~busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      cfg_q   <= '0;
    end else begin
      if (access) ack_q <= 1'b1;
      else if (!cfg_req_i) ack_q <= 1'b0; // release one cycle after req drops
      start_q <= start_d;
      if (start_d) done_q <= 1'b0;
      else if (done_i) done_q <= 1'b1; // sticky until the next job
      if (access && cfg_we_i) begin
        case (reg_idx)
          sink_cfg_pkg::REG_BASE:      cfg_q.base      <= cfg_wdata_i;
          sink_cfg_pkg::REG_D0_STRIDE: cfg_q.d0_stride <= cfg_wdata_i;
          sink_cfg_pkg::REG_D0_LEN:    cfg_q.d0_len    <= cfg_wdata_i[15:0];
          sink_cfg_pkg::REG_D1_STRIDE: cfg_q.d1_stride <= cfg_wdata_i;
          sink_cfg_pkg::REG_TOT_LEN:   cfg_q.tot_len   <= cfg_wdata_i[15:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    case (reg_idx)
      sink_cfg_pkg::REG_BASE:      rdata_d = cfg_q.base;
      sink_cfg_pkg::REG_D0_STRIDE: rdata_d = cfg_q.d0_stride;
      sink_cfg_pkg::REG_D0_LEN:    rdata_d = {16'b0, cfg_q.d0_len};
      sink_cfg_pkg::REG_D1_STRIDE: rdata_d = cfg_q.d1_stride;
      sink_cfg_pkg::REG_TOT_LEN:   rdata_d = {16'b0, cfg_q.tot_len};
      sink_cfg_pkg::REG_STATUS: begin
        rdata_d[sink_cfg_pkg::STATUS_BUSY_BIT] = busy;
        rdata_d[sink_cfg_pkg::STATUS_DONE_BIT] = done_q;
      end
      default: rdata_d = '0;
    endcase
  end

  // read data is sampled on the ack edge and held while ack is high
  always_ff @(posedge clk_i) begin
    if (access) rdata_q <= rdata_d;
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;
  assign cfg_o       = cfg_q;
  assign start_o     = start_q;

endmodule

`default_nettype wire

/* common/stream_pkg.sv */
`default_nettype none

package stream_pkg;

  localparam int unsigned DW = 32;
  localparam int unsigned BW = DW / 8; // one strobe per byte

  // incoming data beat
  typedef struct packed {
    logic          valid;
    logic [DW-1:0] data;
    logic [BW-1:0] strb;
  } stream_beat_t;

  // write request towards the shared memory
  typedef struct packed {
    logic          req;
    logic [31:0]   addr; // word address
    logic [BW-1:0] be;
    logic [DW-1:0] data;
  } mem_req_t;

endpackage

`default_nettype wire

/* common/sink_cfg_pkg.sv */
`default_nettype none

package sink_cfg_pkg;

  // register map of the configuration bus
  typedef enum logic [2:0] {
    REG_BASE      = 3'd0,
    REG_D0_STRIDE = 3'd1,
    REG_D0_LEN    = 3'd2,
    REG_D1_STRIDE = 3'd3,
    REG_TOT_LEN   = 3'd4,
    REG_CTRL      = 3'd5,
    REG_STATUS    = 3'd6
  } reg_idx_e;

  // bit positions inside REG_STATUS
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  typedef struct packed {
    logic [31:0] base;
    logic [31:0] d0_stride; // step between words of one run
    logic [15:0] d0_len;    // words per run
    logic [31:0] d1_stride; // step between run starts
    logic [15:0] tot_len;   // writes per job
  } job_cfg_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WORKING,
    ST_DRAIN
  } sink_state_e;

endpackage

`default_nettype wire
